//--- common/rename_cfg.svh
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// architectural register count
`define RENAME_ARCH_REGS 32

// physical register count
// kept above the architectural count
`define RENAME_PHYS_REGS 64

// register value width
`define RENAME_DATA_W 32

`endif

//--- common/rename_pkg.sv
`include "rename_cfg.svh"

package rename_pkg;

    // architectural register index
    typedef logic [$clog2(`RENAME_ARCH_REGS)-1:0] arch_tag_t;

    // physical register index
    typedef logic [$clog2(`RENAME_PHYS_REGS)-1:0] phys_tag_t;

    // one register value
    typedef logic [`RENAME_DATA_W-1:0] reg_data_t;

    // one flag per physical register
    // used by the free list and the ready bits
    typedef logic [`RENAME_PHYS_REGS-1:0] phys_vec_t;

endpackage

//--- arch_map/arch_map_table.sv
`timescale 1ns/1ps

`include "rename_cfg.svh"

module arch_map_table (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  uop_update,
    input  rename_pkg::arch_tag_t arch_rd1,
    input  rename_pkg::arch_tag_t arch_rd2,
    input  rename_pkg::arch_tag_t arch_wr,
    input  rename_pkg::phys_tag_t new_phys,
    input  logic                  rob_update,
    input  rename_pkg::arch_tag_t arch_rob_update,
    input  rename_pkg::phys_tag_t arch_rob_nonspec_phys,
    input  logic                  rollback,
    output rename_pkg::phys_tag_t rd1_phys,
    output rename_pkg::phys_tag_t rd2_phys,
    output rename_pkg::phys_tag_t wr_oldphys
);
    import rename_pkg::*;

    phys_tag_t spec_map [`RENAME_ARCH_REGS];
    phys_tag_t comm_map [`RENAME_ARCH_REGS];
    phys_tag_t comm_next [`RENAME_ARCH_REGS];

    // lookups see the map before this op's own write
    assign rd1_phys   = spec_map[arch_rd1];
    assign rd2_phys   = spec_map[arch_rd2];
    assign wr_oldphys = spec_map[arch_wr];

    // committed map after this cycle's retire
    always_comb begin
        comm_next = comm_map;
        if (rob_update) begin
            comm_next[arch_rob_update] = arch_rob_nonspec_phys;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // identity mapping out of reset
            for (int i = 0; i < `RENAME_ARCH_REGS; i++) begin
                spec_map[i] <= phys_tag_t'(i);
                comm_map[i] <= phys_tag_t'(i);
            end
        end else begin
            comm_map <= comm_next;
            if (rollback) begin
                // restore sees a retire from the same cycle
                spec_map <= comm_next;
            end else if (uop_update) begin
                spec_map[arch_wr] <= new_phys;
            end
        end
    end

endmodule

//--- phys_file/free_list.sv
`timescale 1ns/1ps

`include "rename_cfg.svh"

module free_list (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  alloc,
    input  logic                  rob_update,
    input  rename_pkg::phys_tag_t phys_rob_nonspec,
    input  rename_pkg::phys_tag_t phys_rob_free,
    input  logic                  rollback,
    output rename_pkg::phys_tag_t next_free,
    output logic                  none_free
);
    import rename_pkg::*;

    phys_vec_t spec_used;
    phys_vec_t comm_used;
    phys_vec_t spec_next;
    phys_vec_t comm_next;

    // lowest clear bit wins, so scan from the top down
    always_comb begin
        next_free = '0;
        for (int i = `RENAME_PHYS_REGS - 1; i >= 0; i--) begin
            if (!spec_used[i]) begin
                next_free = phys_tag_t'(i);
            end
        end
    end

    assign none_free = &spec_used;

    always_comb begin
        comm_next = comm_used;
        if (rob_update) begin
            comm_next[phys_rob_nonspec] = 1'b1;
            comm_next[phys_rob_free]    = 1'b0;
        end
    end

    always_comb begin
        spec_next = spec_used;
        if (alloc) begin
            spec_next[next_free] = 1'b1;
        end
        if (rob_update) begin
            spec_next[phys_rob_free] = 1'b0;
        end
        // rollback drops every speculative allocation
        if (rollback) begin
            spec_next = comm_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // tags below the arch count hold the initial mapping
            for (int i = 0; i < `RENAME_PHYS_REGS; i++) begin
                spec_used[i] <= (i < `RENAME_ARCH_REGS);
                comm_used[i] <= (i < `RENAME_ARCH_REGS);
            end
        end else begin
            spec_used <= spec_next;
            comm_used <= comm_next;
        end
    end

endmodule

//--- phys_file/phys_data_file.sv
`timescale 1ns/1ps

`include "rename_cfg.svh"

module phys_data_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  reserve,
    input  rename_pkg::phys_tag_t reserve_tag,
    input  logic                  ring_update,
    input  rename_pkg::phys_tag_t phys_ring,
    input  rename_pkg::reg_data_t phys_ring_val,
    input  rename_pkg::phys_tag_t rd1_tag,
    input  rename_pkg::phys_tag_t rd2_tag,
    output logic                  rd1_rdy,
    output logic                  rd2_rdy,
    output rename_pkg::reg_data_t rd1_val,
    output rename_pkg::reg_data_t rd2_val
);
    import rename_pkg::*;

    reg_data_t value_mem [`RENAME_PHYS_REGS];
    phys_vec_t ready;
    logic      rd1_hit;
    logic      rd2_hit;

    // ring write in the read cycle
    assign rd1_hit = ring_update && (phys_ring == rd1_tag);
    assign rd2_hit = ring_update && (phys_ring == rd2_tag);

    assign rd1_rdy = rd1_hit || ready[rd1_tag];
    assign rd2_rdy = rd2_hit || ready[rd2_tag];
    assign rd1_val = rd1_hit ? phys_ring_val : value_mem[rd1_tag];
    assign rd2_val = rd2_hit ? phys_ring_val : value_mem[rd2_tag];

    always_ff @(posedge clk) begin
        if (reset) begin
            // initial mappings start ready and zero
            for (int i = 0; i < `RENAME_PHYS_REGS; i++) begin
                value_mem[i] <= '0;
                ready[i]     <= (i < `RENAME_ARCH_REGS);
            end
        end else begin
            if (reserve) begin
                ready[reserve_tag] <= 1'b0;
            end
            // the ring write comes last and beats a reserve to the same tag
            if (ring_update) begin
                value_mem[phys_ring] <= phys_ring_val;
                ready[phys_ring]     <= 1'b1;
            end
        end
    end

endmodule

//--- phys_file/phys_reg_file.sv
`timescale 1ns/1ps

module phys_reg_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  alloc,
    input  logic                  rob_update,
    input  rename_pkg::phys_tag_t phys_rob_nonspec,
    input  rename_pkg::phys_tag_t phys_rob_free,
    input  logic                  rollback,
    input  logic                  ring_update,
    input  rename_pkg::phys_tag_t phys_ring,
    input  rename_pkg::reg_data_t phys_ring_val,
    input  rename_pkg::phys_tag_t rd1_tag,
    input  rename_pkg::phys_tag_t rd2_tag,
    output logic                  rd1_rdy,
    output logic                  rd2_rdy,
    output rename_pkg::reg_data_t rd1_val,
    output rename_pkg::reg_data_t rd2_val,
    output rename_pkg::phys_tag_t next_free,
    output logic                  none_free
);

    free_list fl (
        .clk              (clk),
        .reset            (reset),
        .alloc            (alloc),
        .rob_update       (rob_update),
        .phys_rob_nonspec (phys_rob_nonspec),
        .phys_rob_free    (phys_rob_free),
        .rollback         (rollback),
        .next_free        (next_free),
        .none_free        (none_free)
    );

    // the tag handed out is the one whose ready bit drops
    phys_data_file pdf (
        .clk           (clk),
        .reset         (reset),
        .reserve       (alloc),
        .reserve_tag   (next_free),
        .ring_update   (ring_update),
        .phys_ring     (phys_ring),
        .phys_ring_val (phys_ring_val),
        .rd1_tag       (rd1_tag),
        .rd2_tag       (rd2_tag),
        .rd1_rdy       (rd1_rdy),
        .rd2_rdy       (rd2_rdy),
        .rd1_val       (rd1_val),
        .rd2_val       (rd2_val)
    );

endmodule

//--- verilog/rename_regfile.sv
`timescale 1ns/1ps

module rename_regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  uop_update,
    input  rename_pkg::arch_tag_t arch_rd1,
    input  rename_pkg::arch_tag_t arch_rd2,
    input  rename_pkg::arch_tag_t arch_wr,
    output logic                  none_free,
    input  logic                  ring_update,
    input  rename_pkg::phys_tag_t phys_ring,
    input  rename_pkg::reg_data_t phys_ring_val,
    input  logic                  rob_update,
    input  rename_pkg::arch_tag_t arch_rob_update,
    input  rename_pkg::phys_tag_t arch_rob_nonspec_phys,
    input  rename_pkg::phys_tag_t phys_rob_free,
    input  logic                  rollback,
    output logic                  result_valid,
    output rename_pkg::phys_tag_t phys_rd1,
    output rename_pkg::phys_tag_t phys_rd2,
    output logic                  phys_rd1_rdy,
    output logic                  phys_rd2_rdy,
    output rename_pkg::reg_data_t phys_rd1_val,
    output rename_pkg::reg_data_t phys_rd2_val,
    output rename_pkg::phys_tag_t phys_wr,
    output rename_pkg::phys_tag_t oldphys_wr
);
    import rename_pkg::*;

    logic      accept;
    phys_tag_t map_rd1, map_rd2, map_oldwr, next_free;
    logic      s1_valid;
    phys_tag_t s1_rd1, s1_rd2, s1_wr, s1_oldwr;
    logic      rd1_rdy, rd2_rdy;
    reg_data_t rd1_val, rd2_val;

    // rename only when a tag is available and no rollback
    assign accept = uop_update && !none_free && !rollback;

    arch_map_table amt (
        .clk                   (clk),
        .reset                 (reset),
        .uop_update            (accept),
        .arch_rd1              (arch_rd1),
        .arch_rd2              (arch_rd2),
        .arch_wr               (arch_wr),
        .new_phys              (next_free),
        .rob_update            (rob_update),
        .arch_rob_update       (arch_rob_update),
        .arch_rob_nonspec_phys (arch_rob_nonspec_phys),
        .rollback              (rollback),
        .rd1_phys              (map_rd1),
        .rd2_phys              (map_rd2),
        .wr_oldphys            (map_oldwr)
    );

    phys_reg_file prf (
        .clk              (clk),
        .reset            (reset),
        .alloc            (accept),
        .rob_update       (rob_update),
        .phys_rob_nonspec (arch_rob_nonspec_phys),
        .phys_rob_free    (phys_rob_free),
        .rollback         (rollback),
        .ring_update      (ring_update),
        .phys_ring        (phys_ring),
        .phys_ring_val    (phys_ring_val),
        .rd1_tag          (s1_rd1),
        .rd2_tag          (s1_rd2),
        .rd1_rdy          (rd1_rdy),
        .rd2_rdy          (rd2_rdy),
        .rd1_val          (rd1_val),
        .rd2_val          (rd2_val),
        .next_free        (next_free),
        .none_free        (none_free)
    );

    always_ff @(posedge clk) begin
        if (reset || rollback) begin
            s1_valid     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            s1_valid     <= accept;
            result_valid <= s1_valid;
        end
    end

    // stage 1 tags, stage 2 results
    always_ff @(posedge clk) begin
        s1_rd1       <= map_rd1;
        s1_rd2       <= map_rd2;
        s1_wr        <= next_free;
        s1_oldwr     <= map_oldwr;
        phys_rd1     <= s1_rd1;
        phys_rd2     <= s1_rd2;
        phys_rd1_rdy <= rd1_rdy;
        phys_rd2_rdy <= rd2_rdy;
        phys_rd1_val <= rd1_val;
        phys_rd2_val <= rd2_val;
        phys_wr      <= s1_wr;
        oldphys_wr   <= s1_oldwr;
    end

endmodule

//--- bench/rename_tb.sv
`timescale 1ns/1ps

`include "rename_cfg.svh"

module rename_tb;
    import rename_pkg::*;

    typedef struct packed {
        phys_tag_t rd1;
        phys_tag_t rd2;
        phys_tag_t wr;
        phys_tag_t old;
        logic      rdy1;
        logic      rdy2;
        reg_data_t val1;
        reg_data_t val2;
    } op_t;

    typedef struct packed {
        arch_tag_t arch;
        phys_tag_t new_tag;
        phys_tag_t old_tag;
    } rob_ent_t;

    localparam int n_cycles = 1500;
    localparam int time_limit = (n_cycles + 10) * 100 + 10000;

    logic      clk;
    logic      reset;
    logic      uop_update;
    arch_tag_t arch_rd1, arch_rd2, arch_wr;
    logic      none_free;
    logic      ring_update;
    phys_tag_t phys_ring;
    reg_data_t phys_ring_val;
    logic      rob_update;
    arch_tag_t arch_rob_update;
    phys_tag_t arch_rob_nonspec_phys, phys_rob_free;
    logic      rollback;
    logic      result_valid;
    phys_tag_t phys_rd1, phys_rd2, phys_wr, oldphys_wr;
    logic      phys_rd1_rdy, phys_rd2_rdy;
    reg_data_t phys_rd1_val, phys_rd2_val;

    // reference model state
    phys_tag_t m_spec [`RENAME_ARCH_REGS];
    phys_tag_t m_comm [`RENAME_ARCH_REGS];
    phys_vec_t m_spec_used, m_comm_used, m_ready;
    reg_data_t m_val [`RENAME_PHYS_REGS];
    op_t       flight[$];
    rob_ent_t  rob_q[$];
    op_t       exp_op;
    logic      exp_valid;

    integer    seed;
    int        cyc;
    int        val_errors;
    int        proto_errors;

    rename_regfile dut (.*);

    always #50 clk = ~clk;

    task automatic check_tag(string name, phys_tag_t got, phys_tag_t want);
        if (got !== want) begin
            $display("FAILED %0t %s got %0d expected %0d", $time, name, got, want);
            val_errors++;
        end
    endtask

    task automatic check_data(string name, reg_data_t got, reg_data_t want);
        if (got !== want) begin
            $display("FAILED %0t %s got %h expected %h", $time, name, got, want);
            val_errors++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic want);
        if (got !== want) begin
            $display("FAILED %0t %s got %b expected %b", $time, name, got, want);
            val_errors++;
        end
    endtask

    function automatic phys_tag_t lowest_free(phys_vec_t used);
        for (int i = 0; i < `RENAME_PHYS_REGS; i++) begin
            if (!used[i]) begin
                return phys_tag_t'(i);
            end
        end
        return '0;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < `RENAME_ARCH_REGS; i++) begin
            m_spec[i] = phys_tag_t'(i);
            m_comm[i] = phys_tag_t'(i);
        end
        for (int i = 0; i < `RENAME_PHYS_REGS; i++) begin
            m_val[i]       = '0;
            m_ready[i]     = (i < `RENAME_ARCH_REGS);
            m_spec_used[i] = (i < `RENAME_ARCH_REGS);
            m_comm_used[i] = (i < `RENAME_ARCH_REGS);
        end
        flight.delete();
        rob_q.delete();
        exp_valid = 1'b0;
    endtask

    // effect of the coming edge on the model
    task automatic model_step();
        op_t       op;
        phys_tag_t nf;
        logic      accept;
        phys_vec_t comm_used_next;
        rob_ent_t  ent;
        nf = lowest_free(m_spec_used);
        accept = uop_update && !(&m_spec_used) && !rollback;
        exp_valid = 1'b0;
        if (rollback) begin
            flight.delete();
        end else if (flight.size() > 0) begin
            // stage 1 read with the ring write bypassed
            op = flight.pop_front();
            op.rdy1 = m_ready[op.rd1];
            op.val1 = m_val[op.rd1];
            op.rdy2 = m_ready[op.rd2];
            op.val2 = m_val[op.rd2];
            if (ring_update && phys_ring == op.rd1) begin
                op.rdy1 = 1'b1;
                op.val1 = phys_ring_val;
            end
            if (ring_update && phys_ring == op.rd2) begin
                op.rdy2 = 1'b1;
                op.val2 = phys_ring_val;
            end
            exp_op = op;
            exp_valid = 1'b1;
        end
        if (accept) begin
            op = '0;
            op.rd1 = m_spec[arch_rd1];
            op.rd2 = m_spec[arch_rd2];
            op.wr = nf;
            op.old = m_spec[arch_wr];
            flight.push_back(op);
            ent.arch = arch_wr;
            ent.new_tag = nf;
            ent.old_tag = m_spec[arch_wr];
            rob_q.push_back(ent);
            m_ready[nf] = 1'b0;
        end
        if (ring_update) begin
            m_val[phys_ring] = phys_ring_val;
            m_ready[phys_ring] = 1'b1;
        end
        comm_used_next = m_comm_used;
        if (rob_update) begin
            m_comm[arch_rob_update] = arch_rob_nonspec_phys;
            comm_used_next[arch_rob_nonspec_phys] = 1'b1;
            comm_used_next[phys_rob_free] = 1'b0;
        end
        if (rollback) begin
            m_spec = m_comm;
            m_spec_used = comm_used_next;
        end else begin
            if (accept) begin
                m_spec[arch_wr] = nf;
                m_spec_used[nf] = 1'b1;
            end
            if (rob_update) begin
                m_spec_used[phys_rob_free] = 1'b0;
            end
        end
        m_comm_used = comm_used_next;
    endtask

    task automatic drive_inputs();
        logic [31:0] r, r2, r3;
        logic [4:0]  mask;
        logic        no_commit;
        int          idx;
        rob_ent_t    ent;
        r = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        // every other window retires nothing, so the tags run out
        no_commit = ((cyc / 250) % 2) == 1;
        // a narrow register range gives rename chains
        mask = r2[31] ? 5'h03 : 5'h1f;
        uop_update = (r[9:8] != 2'b00);
        arch_rd1 = r2[4:0] & mask;
        arch_rd2 = r2[9:5] & mask;
        arch_wr = r2[14:10] & mask;
        rob_update = 1'b0;
        rollback = 1'b0;
        ring_update = 1'b0;
        if (!no_commit && rob_q.size() > 0 && r[6]) begin
            ent = rob_q.pop_front();
            rob_update = 1'b1;
            arch_rob_update = ent.arch;
            arch_rob_nonspec_phys = ent.new_tag;
            phys_rob_free = ent.old_tag;
        end
        if (!no_commit && r[5:0] == 6'd0) begin
            rollback = 1'b1;
        end
        if (r[10] && rob_q.size() > 0) begin
            idx = int'(r3 % rob_q.size());
            ring_update = 1'b1;
            phys_ring = rob_q[idx].new_tag;
            phys_ring_val = $random(seed);
        end
        if (rollback) begin
            rob_q.delete();
        end
    endtask

    task automatic check_outputs();
        check_bit("none_free", none_free, &m_spec_used);
        if (exp_valid && result_valid !== 1'b1) begin
            $display("%0t a result was expected but result_valid stayed low", $time);
            proto_errors++;
        end else if (!exp_valid && result_valid !== 1'b0) begin
            $display("%0t result_valid rose with no result expected", $time);
            proto_errors++;
        end else if (exp_valid) begin
            check_tag("phys_rd1", phys_rd1, exp_op.rd1);
            check_tag("phys_rd2", phys_rd2, exp_op.rd2);
            check_tag("phys_wr", phys_wr, exp_op.wr);
            check_tag("oldphys_wr", oldphys_wr, exp_op.old);
            check_bit("phys_rd1_rdy", phys_rd1_rdy, exp_op.rdy1);
            check_bit("phys_rd2_rdy", phys_rd2_rdy, exp_op.rdy2);
            check_data("phys_rd1_val", phys_rd1_val, exp_op.val1);
            check_data("phys_rd2_val", phys_rd2_val, exp_op.val2);
        end
    endtask

    initial begin
        #(time_limit);
        $display("timeout: the run did not reach its end in time");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        seed = 32'hb4ba;
        val_errors = 0;
        proto_errors = 0;
        clk = 1'b0;
        reset = 1'b1;
        uop_update = 1'b0;
        arch_rd1 = '0;
        arch_rd2 = '0;
        arch_wr = '0;
        ring_update = 1'b0;
        phys_ring = '0;
        phys_ring_val = '0;
        rob_update = 1'b0;
        arch_rob_update = '0;
        arch_rob_nonspec_phys = '0;
        phys_rob_free = '0;
        rollback = 1'b0;
        model_reset();
        repeat (10) @(posedge clk);
        #5;
        reset = 1'b0;
        for (cyc = 0; cyc < n_cycles; cyc++) begin
            check_outputs();
            drive_inputs();
            model_step();
            @(posedge clk);
            #5;
        end
        check_outputs();
        $display("errors: %0d value mismatches, %0d result protocol errors",
                 val_errors, proto_errors);
        if (val_errors + proto_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+common
common/rename_pkg.sv
arch_map/arch_map_table.sv
phys_file/free_list.sv
phys_file/phys_data_file.sv
phys_file/phys_reg_file.sv
verilog/rename_regfile.sv
bench/rename_tb.sv

//--- run.sh
#!/bin/sh
# build the rename testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f list.f --top-module rename_tb -o rename_sim
./obj_dir/rename_sim | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
